/* cim_settings.svh */
`ifndef CIM_SETTINGS_SVH
`define CIM_SETTINGS_SVH

// stored instruction layout
`define STORED_INSTR_WIDTH 32
`define ADDR_WIDTH         8
`define OPCODE_WIDTH       4
`define OPCODE_LSB         28  // opcode in bits 31:28
`define PRECISION_WIDTH    4
`define PRECISION_LSB      0   // legal precision 2 to 15
`define ROW_ADDR_WIDTH     7
`define SRC1_ROW_LSB       4   // bits 10:4
`define SRC2_ROW_LSB       11  // bits 17:11, rf index for ADD_CONST
`define DST_ROW_LSB        18  // bits 24:18

// constant register file
`define RF_ADDR_WIDTH      2
`define RF_COUNT           4
`define RF_WIDTH           16

// array command word
`define CMD_WIDTH          40  // sum of the array_cmd_t fields
`define CMD_ADDR           8'hff  // fixed address tied on the array side

`endif

/* cim_pkg.sv */
`include "cim_settings.svh"

package cim_pkg;

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        OP_ADD       = 4'd1,
        OP_MUL       = 4'd3,
        OP_ADD_CONST = 4'd4
    } opcode_e;  // all other codes are skipped

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADD_BIT,
        ST_ADD_CARRY,
        ST_MUL_CLEAR,
        ST_MUL_MASK,
        ST_MUL_COPY,
        ST_MUL_ACC,
        ST_MUL_CARRY
    } seq_state_e;

    typedef struct packed {
        opcode_e                     op;
        logic [`PRECISION_WIDTH-1:0] precision;
        logic [`ROW_ADDR_WIDTH-1:0]  src1_row;
        logic [`ROW_ADDR_WIDTH-1:0]  src2_row;
        logic [`ROW_ADDR_WIDTH-1:0]  dst_row;
        logic [`RF_ADDR_WIDTH-1:0]   rf_sel;  // constant register, ADD_CONST only
    } decoded_instr_t;

    typedef struct packed {
        logic [1:0]                 predicate;    // 11 always write, 00 per mask
        logic [4:0]                 pad;
        logic                       write_en;
        logic [1:0]                 write_sel;
        logic                       port;         // 1 selects the carry port
        logic                       c_rst;
        logic                       c_en;
        logic                       m_rst;
        logic                       m_en;
        logic [3:0]                 truth_table;
        logic [`ROW_ADDR_WIDTH-1:0] dst;
        logic [`ROW_ADDR_WIDTH-1:0] src2;
        logic [`ROW_ADDR_WIDTH-1:0] src1;
    } array_cmd_t;

endpackage

/* instr_fetch.sv */
`include "cim_settings.svh"

module instr_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [`ADDR_WIDTH-1:0] start_addr,
    input  logic [`ADDR_WIDTH-1:0] end_addr,
    input  logic                   last_cmd,
    input  logic                   seq_idle,
    output logic [`ADDR_WIDTH-1:0] stored_instr_addr,
    output logic                   load,
    output logic                   done
);

    logic [`ADDR_WIDTH-1:0] addr_q;
    logic                   first;      // nothing fetched since start rose
    logic                   in_flight;  // an instruction sits in decode or sequencer
    logic                   past_end;   // end address already fetched

    // memory sees the start address for as long as start is low
    assign stored_instr_addr = start ? addr_q : start_addr;

    assign load = start && !past_end &&
                  (first || last_cmd || (seq_idle && !in_flight));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q    <= '0;
            first     <= 1'b1;
            in_flight <= 1'b0;
            past_end  <= 1'b0;
            done      <= 1'b0;
        end else if (!start) begin
            addr_q    <= start_addr;  // restart point
            first     <= 1'b1;
            in_flight <= 1'b0;
            past_end  <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (load) begin
                addr_q    <= addr_q + 1'b1;
                first     <= 1'b0;
                in_flight <= 1'b1;
                if (addr_q == end_addr) begin
                    past_end <= 1'b1;
                end
            end else if (last_cmd) begin
                in_flight <= 1'b0;  // final command of the last instruction
            end
            if (past_end && !in_flight) begin
                done <= 1'b1;  // sticky until start drops
            end
        end
    end

endmodule

/* instr_decode.sv */
`include "cim_settings.svh"

module instr_decode import cim_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic                          load,
    input  logic [`STORED_INSTR_WIDTH-1:0] stored_instruction,
    output decoded_instr_t                instr,
    output logic                          instr_valid
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= start && load;  // one cycle pulse per fetch
        end
    end

    // ADD, ADD_CONST and MUL share one field layout
    always_ff @(posedge clk) begin
        if (load) begin
            instr.op        <= opcode_e'(stored_instruction[`OPCODE_LSB +: `OPCODE_WIDTH]);
            instr.precision <= stored_instruction[`PRECISION_LSB +: `PRECISION_WIDTH];
            instr.src1_row  <= stored_instruction[`SRC1_ROW_LSB +: `ROW_ADDR_WIDTH];
            instr.src2_row  <= stored_instruction[`SRC2_ROW_LSB +: `ROW_ADDR_WIDTH];
            instr.dst_row   <= stored_instruction[`DST_ROW_LSB +: `ROW_ADDR_WIDTH];
            instr.rf_sel    <= stored_instruction[`SRC2_ROW_LSB +: `RF_ADDR_WIDTH];
        end
    end

endmodule

/* const_bit_stream.sv */
`include "cim_settings.svh"

module const_bit_stream (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [`RF_COUNT-1:0][`RF_WIDTH-1:0]   rf,
    input  logic [`RF_ADDR_WIDTH-1:0]             rf_sel,
    input  logic                                  capture,
    input  logic                                  shift,
    output logic                                  bit_out
);

    logic [`RF_WIDTH-1:0] bits_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bits_q <= '0;
        end else if (capture) begin
            bits_q <= rf[rf_sel];  // load selected constant
        end else if (shift) begin
            bits_q <= bits_q >> 1;  // next bit for next sum command
        end
    end

    assign bit_out = bits_q[0];  // lsb first

endmodule

/* op_sequencer.sv */
`include "cim_settings.svh"

module op_sequencer import cim_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  logic           instr_valid,
    input  decoded_instr_t instr,
    input  logic           const_bit,
    output array_cmd_t     cmd,
    output logic           cmd_valid,
    output logic           last_cmd,
    output logic           seq_idle,
    output logic           const_capture,
    output logic           const_shift
);

    seq_state_e                  state;
    logic [`PRECISION_WIDTH-1:0] i;  // bit index
    logic [`PRECISION_WIDTH-1:0] j;  // partial product index
    logic [`PRECISION_WIDTH-1:0] p_last;
    logic [`ROW_ADDR_WIDTH-1:0]  i_off;
    logic [`ROW_ADDR_WIDTH-1:0]  j_off;
    logic [`ROW_ADDR_WIDTH-1:0]  p_off;
    logic                        bit_last;
    logic                        supported;

    assign p_last    = instr.precision - 1'b1;
    assign bit_last  = (i == p_last);
    assign i_off     = {{(`ROW_ADDR_WIDTH-`PRECISION_WIDTH){1'b0}}, i};
    assign j_off     = {{(`ROW_ADDR_WIDTH-`PRECISION_WIDTH){1'b0}}, j};
    assign p_off     = {{(`ROW_ADDR_WIDTH-`PRECISION_WIDTH){1'b0}}, instr.precision};
    assign supported = instr.op inside {OP_ADD, OP_ADD_CONST, OP_MUL};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            i     <= '0;
            j     <= '0;
        end else if (!start) begin
            state <= ST_IDLE;
            i     <= '0;
            j     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    i <= '0;
                    j <= '0;
                    if (instr_valid) begin
                        case (instr.op)
                            OP_ADD, OP_ADD_CONST: state <= ST_ADD_BIT;
                            OP_MUL:               state <= ST_MUL_CLEAR;
                            default:              state <= ST_IDLE;  // skipped
                        endcase
                    end
                end
                ST_ADD_BIT: begin
                    i <= i + 1'b1;
                    if (bit_last) begin
                        state <= ST_ADD_CARRY;
                    end
                end
                ST_ADD_CARRY: begin
                    state <= ST_IDLE;
                end
                ST_MUL_CLEAR: begin
                    if (bit_last) begin
                        i     <= '0;
                        state <= ST_MUL_MASK;
                    end else begin
                        i <= i + 1'b1;
                    end
                end
                ST_MUL_MASK: begin
                    i <= '0;
                    if (j == '0) begin
                        state <= ST_MUL_COPY;  // first partial product is a copy
                    end else begin
                        state <= ST_MUL_ACC;
                    end
                end
                ST_MUL_COPY: begin
                    if (bit_last) begin
                        j     <= {{(`PRECISION_WIDTH-1){1'b0}}, 1'b1};
                        state <= ST_MUL_MASK;
                    end else begin
                        i <= i + 1'b1;
                    end
                end
                ST_MUL_ACC: begin
                    if (bit_last) begin
                        state <= ST_MUL_CARRY;
                    end else begin
                        i <= i + 1'b1;
                    end
                end
                ST_MUL_CARRY: begin
                    if (j == p_last) begin
                        state <= ST_IDLE;
                    end else begin
                        j     <= j + 1'b1;
                        state <= ST_MUL_MASK;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign seq_idle      = (state == ST_IDLE);
    assign cmd_valid     = (state != ST_IDLE);
    assign const_capture = (state == ST_IDLE) && instr_valid;
    assign const_shift   = (state == ST_ADD_BIT);

    always_comb begin
        cmd      = '0;
        last_cmd = 1'b0;
        if (state != ST_IDLE) begin
            cmd.write_en  = 1'b1;
            cmd.write_sel = 2'b01;
        end
        case (state)
            ST_IDLE: begin
                last_cmd = instr_valid && !supported;  // nothing to issue
            end
            ST_ADD_BIT: begin
                cmd.predicate = 2'b11;
                cmd.c_en      = 1'b1;
                if (instr.op == OP_ADD_CONST) begin
                    cmd.truth_table = const_bit ? 4'b0101 : 4'b1010;
                end else begin
                    cmd.truth_table = 4'b0110;  // xor
                end
                cmd.src1 = instr.src1_row + i_off;
                cmd.src2 = instr.src2_row + i_off;
                cmd.dst  = instr.dst_row + i_off;
            end
            ST_ADD_CARRY: begin
                cmd.predicate   = 2'b11;
                cmd.port        = 1'b1;  // carry out on second port
                cmd.c_rst       = 1'b1;
                cmd.truth_table = 4'b0110;
                cmd.src1        = instr.src1_row + p_off;
                cmd.src2        = instr.src2_row + p_off;
                cmd.dst         = instr.dst_row + p_off;
                last_cmd        = 1'b1;
            end
            ST_MUL_CLEAR: begin
                cmd.predicate = 2'b11;  // truth 0000 writes zeros
                cmd.src1      = instr.src1_row;
                cmd.src2      = instr.src2_row;
                cmd.dst       = instr.dst_row + p_off + i_off;
            end
            ST_MUL_MASK: begin
                cmd.write_en    = 1'b0;
                cmd.m_en        = 1'b1;
                cmd.truth_table = 4'b1010;  // pass src1 bit into mask
                cmd.src1        = instr.src1_row + j_off;
                cmd.src2        = instr.src2_row;
                cmd.dst         = instr.dst_row;
            end
            ST_MUL_COPY: begin
                cmd.truth_table = 4'b1100;  // pass src2
                cmd.src1        = instr.src1_row;
                cmd.src2        = instr.src2_row + i_off;
                cmd.dst         = instr.dst_row + i_off;
            end
            ST_MUL_ACC: begin
                cmd.c_en        = 1'b1;
                cmd.truth_table = 4'b0110;
                cmd.src1        = instr.dst_row + j_off + i_off;
                cmd.src2        = instr.src2_row + i_off;
                cmd.dst         = instr.dst_row + j_off + i_off;
            end
            ST_MUL_CARRY: begin
                cmd.port        = 1'b1;
                cmd.c_en        = 1'b1;
                cmd.truth_table = 4'b0110;
                cmd.src1        = instr.src1_row;
                cmd.src2        = instr.src2_row;
                cmd.dst         = instr.dst_row + j_off + p_off;
                last_cmd        = (j == p_last);
            end
            default: begin
                last_cmd = 1'b0;
            end
        endcase
    end

endmodule

/* cim_controller.sv */
`include "cim_settings.svh"

module cim_controller import cim_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic [`ADDR_WIDTH-1:0]         stored_instr_start_addr,
    input  logic [`ADDR_WIDTH-1:0]         stored_instr_end_addr,
    input  logic [`STORED_INSTR_WIDTH-1:0] stored_instruction,
    input  logic [`RF_WIDTH-1:0]           rf0,
    input  logic [`RF_WIDTH-1:0]           rf1,
    input  logic [`RF_WIDTH-1:0]           rf2,
    input  logic [`RF_WIDTH-1:0]           rf3,
    output logic [`ADDR_WIDTH-1:0]         stored_instr_addr,
    output logic [`CMD_WIDTH-1:0]          exec_instruction,
    output logic                           execute,
    output logic                           done
);

    decoded_instr_t instr;
    array_cmd_t     cmd;
    logic           load;
    logic           instr_valid;
    logic           cmd_valid;
    logic           last_cmd;
    logic           seq_idle;
    logic           const_capture;
    logic           const_shift;
    logic           const_bit;

    instr_fetch i_instr_fetch (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .start_addr        (stored_instr_start_addr),
        .end_addr          (stored_instr_end_addr),
        .last_cmd          (last_cmd),
        .seq_idle          (seq_idle),
        .stored_instr_addr (stored_instr_addr),
        .load              (load),
        .done              (done)
    );

    instr_decode i_instr_decode (
        .clk                (clk),
        .rst_n              (rst_n),
        .start              (start),
        .load               (load),
        .stored_instruction (stored_instruction),
        .instr              (instr),
        .instr_valid        (instr_valid)
    );

    const_bit_stream i_const_bit_stream (
        .clk     (clk),
        .rst_n   (rst_n),
        .rf      ({rf3, rf2, rf1, rf0}),  // index 0 is rf0
        .rf_sel  (instr.rf_sel),
        .capture (const_capture),
        .shift   (const_shift),
        .bit_out (const_bit)
    );

    op_sequencer i_op_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .const_bit     (const_bit),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .last_cmd      (last_cmd),
        .seq_idle      (seq_idle),
        .const_capture (const_capture),
        .const_shift   (const_shift)
    );

    assign exec_instruction = cmd;  // packed struct straight onto the bus
    assign execute          = cmd_valid && !done;

endmodule

/* tb_cim_controller.sv */
`include "cim_settings.svh"

module tb_cim_controller;

    localparam logic [3:0]  OPC_ADD       = 4'd1;
    localparam logic [3:0]  OPC_MUL       = 4'd3;
    localparam logic [3:0]  OPC_ADD_CONST = 4'd4;
    localparam logic [3:0]  OPC_SKIPPED   = 4'd7;  // no commands expected
    localparam int unsigned SEED          = 32'h8c58_4201;

    logic                           clk;
    logic                           rst_n;
    logic                           start;
    logic [`ADDR_WIDTH-1:0]         start_addr;
    logic [`ADDR_WIDTH-1:0]         end_addr;
    logic [`STORED_INSTR_WIDTH-1:0] stored_instruction;
    logic [`RF_WIDTH-1:0]           rf_val [`RF_COUNT];
    logic [`ADDR_WIDTH-1:0]         stored_instr_addr;
    logic [`CMD_WIDTH-1:0]          exec_instruction;
    logic                           execute;
    logic                           done;

    logic [`STORED_INSTR_WIDTH-1:0] imem [0:255];
    logic [`STORED_INSTR_WIDTH-1:0] prog [$];  // all test instructions
    logic [`CMD_WIDTH-1:0]          got_q [$];
    logic [`CMD_WIDTH-1:0]          exp_q [$];
    int                             budget;

    cim_controller i_cim_controller (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .start                   (start),
        .stored_instr_start_addr (start_addr),
        .stored_instr_end_addr   (end_addr),
        .stored_instruction      (stored_instruction),
        .rf0                     (rf_val[0]),
        .rf1                     (rf_val[1]),
        .rf2                     (rf_val[2]),
        .rf3                     (rf_val[3]),
        .stored_instr_addr       (stored_instr_addr),
        .exec_instruction        (exec_instruction),
        .execute                 (execute),
        .done                    (done)
    );

    assign stored_instruction = imem[stored_instr_addr];  // same cycle read

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (rst_n && execute) begin
            got_q.push_back(exec_instruction);
        end
    end

    function automatic logic [31:0] fill_word(input logic [7:0] a);
        fill_word = {4'hf, 4'h0, a, ~a, a};  // opcode 15 never executes
    endfunction

    function automatic logic [31:0] encode(input logic [3:0] op, input logic [6:0] dst,
                                           input logic [6:0] src2, input logic [6:0] src1,
                                           input logic [3:0] prec);
        encode = {op, 3'b000, dst, src2, src1, prec};
    endfunction

    function automatic logic [6:0] rand_row();
        rand_row = 7'($urandom());
    endfunction

    function automatic logic [3:0] rand_prec(input int max_p);
        rand_prec = 4'(2 + $urandom() % (max_p - 1));  // 2 to max_p
    endfunction

    function automatic logic [6:0] row_plus(input logic [6:0] base, input int off);
        row_plus = 7'(int'(base) + off);  // rows wrap at 128
    endfunction

    function automatic logic [`CMD_WIDTH-1:0] make_cmd(
        input logic [1:0] pred, input logic we, input logic port, input logic c_rst,
        input logic c_en, input logic m_en, input logic [3:0] tt,
        input logic [6:0] dst, input logic [6:0] src2, input logic [6:0] src1);
        // write_sel is 01 and pad, m_rst are 0 in every command
        make_cmd = {pred, 5'b0, we, 2'b01, port, c_rst, c_en, 1'b0, m_en, tt,
                    dst, src2, src1};
    endfunction

    function automatic int cmd_count(input logic [31:0] word);
        int p;
        p = int'(word[`PRECISION_LSB +: `PRECISION_WIDTH]);
        case (word[`OPCODE_LSB +: `OPCODE_WIDTH])
            OPC_ADD, OPC_ADD_CONST: cmd_count = p + 1;
            OPC_MUL:                cmd_count = 2 * p + 1 + (p - 1) * (p + 2);
            default:                cmd_count = 0;
        endcase
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    // expected command stream of one stored instruction
    task automatic expect_instr(input logic [`STORED_INSTR_WIDTH-1:0] word);
        logic [3:0]           op;
        logic [6:0]           s1;
        logic [6:0]           s2;
        logic [6:0]           d;
        logic [`RF_WIDTH-1:0] cval;
        logic [3:0]           tt;
        int                   p;
        int                   j;
        int                   k;
        op   = word[`OPCODE_LSB +: `OPCODE_WIDTH];
        p    = int'(word[`PRECISION_LSB +: `PRECISION_WIDTH]);
        s1   = word[`SRC1_ROW_LSB +: `ROW_ADDR_WIDTH];
        s2   = word[`SRC2_ROW_LSB +: `ROW_ADDR_WIDTH];
        d    = word[`DST_ROW_LSB +: `ROW_ADDR_WIDTH];
        cval = rf_val[s2[1:0]];  // low src2 bits pick the constant
        if (op == OPC_ADD || op == OPC_ADD_CONST) begin
            for (k = 0; k < p; k++) begin
                if (op == OPC_ADD) begin
                    tt = 4'b0110;
                end else if (cval[4'(k)]) begin
                    tt = 4'b0101;
                end else begin
                    tt = 4'b1010;
                end
                exp_q.push_back(make_cmd(2'b11, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, tt,
                                         row_plus(d, k), row_plus(s2, k), row_plus(s1, k)));
            end
            exp_q.push_back(make_cmd(2'b11, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 4'b0110,
                                     row_plus(d, p), row_plus(s2, p), row_plus(s1, p)));
        end else if (op == OPC_MUL) begin
            for (k = 0; k < p; k++) begin  // clear the upper product rows
                exp_q.push_back(make_cmd(2'b11, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 4'b0000,
                                         row_plus(d, p + k), s2, s1));
            end
            exp_q.push_back(make_cmd(2'b00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 4'b1010, d, s2, s1));
            for (k = 0; k < p; k++) begin
                exp_q.push_back(make_cmd(2'b00, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 4'b1100,
                                         row_plus(d, k), row_plus(s2, k), s1));
            end
            for (j = 1; j < p; j++) begin
                exp_q.push_back(make_cmd(2'b00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 4'b1010,
                                         d, s2, row_plus(s1, j)));
                for (k = 0; k < p; k++) begin
                    exp_q.push_back(make_cmd(2'b00, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 4'b0110,
                                             row_plus(d, j + k), row_plus(s2, k),
                                             row_plus(d, j + k)));
                end
                exp_q.push_back(make_cmd(2'b00, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 4'b0110,
                                         row_plus(d, j + p), s2, s1));
            end
        end
    endtask

    task automatic check_idle();
        int c;
        for (c = 0; c < 2; c++) begin
            @(negedge clk);
            check("execute", 64'(execute), 64'(1'b0));
            check("done", 64'(done), 64'(1'b0));
            check("exec_instruction", 64'(exec_instruction), 64'(0));
            check("stored_instr_addr", 64'(stored_instr_addr), 64'(start_addr));
        end
    endtask

    // copies prog[first..last] to memory at base and builds the expected stream
    task automatic load_program(input int base, input int first, input int last);
        int n;
        exp_q.delete();
        @(negedge clk);
        for (n = first; n <= last; n++) begin
            imem[8'(base + n - first)] = prog[n];
            expect_instr(prog[n]);
        end
        start_addr = 8'(base);
        end_addr   = 8'(base + last - first);
    endtask

    task automatic start_program();
        @(negedge clk);  // fetch has latched start_addr by now
        got_q.delete();
        start = 1'b1;
    endtask

    task automatic finish_program();
        int c;
        int n;
        @(negedge clk);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        for (c = 0; c < 3; c++) begin  // quiet once done
            check("execute", 64'(execute), 64'(1'b0));
            check("done", 64'(done), 64'(1'b1));
            @(negedge clk);
        end
        check("command count", 64'(got_q.size()), 64'(exp_q.size()));
        for (n = 0; n < exp_q.size(); n++) begin
            check($sformatf("exec_instruction #%0d", n), 64'(got_q[n]), 64'(exp_q[n]));
        end
        start = 1'b0;
        check_idle();
    endtask

    task automatic run_program(input int base, input int first, input int last);
        load_program(base, first, last);
        start_program();
        finish_program();
    endtask

    task automatic test_add();
        run_program('h10, 0, 0);  // precision 4
        run_program('h18, 1, 1);  // precision 8
    endtask

    task automatic test_add_const();
        run_program('h20, 2, 5);  // one per constant register
    endtask

    task automatic test_mul();
        run_program('h30, 6, 6);
        run_program('h38, 7, 7);
    endtask

    task automatic test_mixed();
        run_program('h40, 8, 11);
    endtask

    task automatic test_restart();
        int stop_after;
        load_program('h50, 8, 11);
        stop_after = cmd_count(prog[8]) + 3;  // somewhere inside the MUL
        start_program();
        while (got_q.size() < stop_after) begin
            @(negedge clk);
        end
        start = 1'b0;
        check_idle();
        start_program();
        finish_program();
    endtask

    initial begin
        int total;
        int n;
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        start_addr = '0;
        end_addr   = '0;
        budget     = 0;
        void'($urandom(SEED));
        for (n = 0; n < 256; n++) begin
            imem[8'(n)] = fill_word(8'(n));
        end
        rf_val[0] = 16'($urandom());
        rf_val[1] = 16'($urandom());
        rf_val[2] = 16'($urandom());
        rf_val[3] = 16'($urandom());

        prog.push_back(encode(OPC_ADD, rand_row(), rand_row(), rand_row(), 4'd4));
        prog.push_back(encode(OPC_ADD, rand_row(), rand_row(), rand_row(), 4'd8));
        for (n = 0; n < 4; n++) begin
            prog.push_back(encode(OPC_ADD_CONST, rand_row(), {5'($urandom()), 2'(n)},
                                  rand_row(), rand_prec(15)));
        end
        prog.push_back(encode(OPC_MUL, rand_row(), rand_row(), rand_row(), 4'd3));
        prog.push_back(encode(OPC_MUL, rand_row(), rand_row(), rand_row(), rand_prec(6)));
        prog.push_back(encode(OPC_ADD, rand_row(), rand_row(), rand_row(), rand_prec(15)));
        prog.push_back(encode(OPC_SKIPPED, rand_row(), rand_row(), rand_row(), rand_prec(15)));
        prog.push_back(encode(OPC_MUL, rand_row(), rand_row(), rand_row(), rand_prec(6)));
        prog.push_back(encode(OPC_ADD_CONST, rand_row(), rand_row(), rand_row(),
                              rand_prec(15)));

        total = 0;
        for (n = 0; n < prog.size(); n++) begin
            total += cmd_count(prog[n]);
        end
        for (n = 8; n < 12; n++) begin
            total += 2 * cmd_count(prog[n]);  // restart test runs it twice more
        end
        budget = total * 8 * 4 + 4000;

        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_idle();

        test_add();
        test_add_const();
        test_mul();
        test_mixed();
        test_restart();

        $display("=== PASS ===");
        $finish;
    end

    initial begin
        wait (budget > 0);
        #(budget);
        $display("timeout: the tests did not finish within %0d time units", budget);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

/* all.f */
+incdir+.
cim_pkg.sv
instr_fetch.sv
instr_decode.sv
const_bit_stream.sv
op_sequencer.sv
cim_controller.sv
tb_cim_controller.sv

/* run.sh */
#!/bin/sh
# build and run the testbench; exit status follows the simulation result
verilator --binary --timing -f all.f --top-module tb_cim_controller -o sim_tb \
    && ./obj_dir/sim_tb \
    || { echo "simulation failed"; exit 1; }
